//--- logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  dlx_pkg::if_id_t                   if_id,
    input  logic [dlx_pkg::xlen-1:0]          rdata1,
    input  logic [dlx_pkg::xlen-1:0]          rdata2,
    output logic [dlx_pkg::reg_addr_w-1:0]    rs1,
    output logic [dlx_pkg::reg_addr_w-1:0]    rs2,
    output dlx_pkg::id_ex_t                   id_ex
);

    dlx_pkg::instr_t          instr;
    dlx_pkg::id_ex_t          id_ex_d;
    logic [dlx_pkg::xlen-1:0] imm_sext;
    logic [dlx_pkg::xlen-1:0] imm_zext;
    logic [dlx_pkg::xlen-1:0] off26_sext;

    assign instr = if_id.instr;

    // source fields sit in the same bits in r and i format
    assign rs1 = instr.r_fmt.rs1;
    assign rs2 = instr.r_fmt.rs2;

    ////////////////////////////////////////
    // immediate extension
    ////////////////////////////////////////

    assign imm_sext = {{(dlx_pkg::xlen - dlx_pkg::imm16_w){instr.i_fmt.imm16[dlx_pkg::imm16_w-1]}},
                       instr.i_fmt.imm16};
    assign imm_zext = {{(dlx_pkg::xlen - dlx_pkg::imm16_w){1'b0}}, instr.i_fmt.imm16};

    // pc relative j offset
    assign off26_sext = {{(dlx_pkg::xlen - dlx_pkg::imm26_w){instr.j_fmt.imm26[dlx_pkg::imm26_w-1]}},
                         instr.j_fmt.imm26};

    ////////////////////////////////////////
    // control decode
    ////////////////////////////////////////

    always_comb begin
        // everything low unless the opcode says otherwise
        id_ex_d           = '0;
        id_ex_d.pc4       = if_id.pc4;
        id_ex_d.op_a      = rdata1;
        id_ex_d.store_val = rdata2;
        id_ex_d.imm       = imm_sext;
        id_ex_d.jump_off  = off26_sext;
        id_ex_d.dest      = instr.i_fmt.rd;

        case (instr.r_fmt.op)
            dlx_pkg::op_rtype: begin
                id_ex_d.dest      = instr.r_fmt.rd;
                id_ex_d.reg_write = 1'b1;
                case (instr.r_fmt.func)
                    dlx_pkg::fn_add: id_ex_d.alu_op = dlx_pkg::alu_add;
                    dlx_pkg::fn_sub: id_ex_d.alu_op = dlx_pkg::alu_sub;
                    dlx_pkg::fn_and: id_ex_d.alu_op = dlx_pkg::alu_and;
                    dlx_pkg::fn_or:  id_ex_d.alu_op = dlx_pkg::alu_or;
                    dlx_pkg::fn_xor: id_ex_d.alu_op = dlx_pkg::alu_xor;
                    dlx_pkg::fn_sll: id_ex_d.alu_op = dlx_pkg::alu_sll;
                    dlx_pkg::fn_srl: id_ex_d.alu_op = dlx_pkg::alu_srl;
                    dlx_pkg::fn_slt: id_ex_d.alu_op = dlx_pkg::alu_slt;
                    // unknown func is a nop
                    default:         id_ex_d.reg_write = 1'b0;
                endcase
            end
            dlx_pkg::op_addi: begin
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_op    = dlx_pkg::alu_add;
            end
            // logical immediates zero extend
            dlx_pkg::op_andi: begin
                id_ex_d.imm       = imm_zext;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_op    = dlx_pkg::alu_and;
            end
            dlx_pkg::op_ori: begin
                id_ex_d.imm       = imm_zext;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_op    = dlx_pkg::alu_or;
            end
            dlx_pkg::op_xori: begin
                id_ex_d.imm       = imm_zext;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_op    = dlx_pkg::alu_xor;
            end
            // address = base + offset
            dlx_pkg::op_lw: begin
                id_ex_d.use_imm    = 1'b1;
                id_ex_d.reg_write  = 1'b1;
                id_ex_d.mem_to_reg = 1'b1;
                id_ex_d.alu_op     = dlx_pkg::alu_add;
            end
            dlx_pkg::op_sw: begin
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.mem_write = 1'b1;
                id_ex_d.alu_op    = dlx_pkg::alu_add;
            end
            dlx_pkg::op_beqz: begin
                id_ex_d.branch      = 1'b1;
                id_ex_d.branch_zero = 1'b1;
            end
            dlx_pkg::op_bnez: begin
                id_ex_d.branch = 1'b1;
            end
            dlx_pkg::op_j: begin
                id_ex_d.jump = 1'b1;
            end
            // unknown opcode leaves every enable low
            default: ;
        endcase
    end

    // id/ex register
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

//--- logic/dlx_pipeline.sv
`timescale 1ns/100ps

module dlx_pipeline (
    input  logic                          clk,
    input  logic                          rst,
    input  dlx_pkg::instr_t               imem_data,
    input  logic [dlx_pkg::xlen-1:0]      dmem_rdata,
    output logic [dlx_pkg::xlen-1:0]      imem_addr,
    output dlx_pkg::dmem_req_t            dmem_req
);

    // stage to stage
    dlx_pkg::if_id_t                if_id;
    dlx_pkg::id_ex_t                id_ex;
    dlx_pkg::ex_mem_t               ex_mem;
    dlx_pkg::wb_t                   wb;

    // register file ports
    logic [dlx_pkg::reg_addr_w-1:0] rs1;
    logic [dlx_pkg::reg_addr_w-1:0] rs2;
    logic [dlx_pkg::xlen-1:0]       rdata1;
    logic [dlx_pkg::xlen-1:0]       rdata2;

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////

    // leap comes back from the ex/mem register
    fetch_stage u_fetch (
        .clk       (clk),
        .rst       (rst),
        .imem_data (imem_data),
        .leap      (ex_mem.leap),
        .leap_addr (ex_mem.leap_addr),
        .pc        (imem_addr),
        .if_id     (if_id)
    );

    ////////////////////////////////////////
    // decode and registers
    ////////////////////////////////////////

    decode_stage u_decode (
        .clk    (clk),
        .rst    (rst),
        .if_id  (if_id),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .rs1    (rs1),
        .rs2    (rs2),
        .id_ex  (id_ex)
    );

    // written from wb, read by decode
    register_file u_regs (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .wb     (wb),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    ////////////////////////////////////////
    // execute, memory, writeback
    ////////////////////////////////////////

    execute_stage u_execute (
        .clk    (clk),
        .rst    (rst),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    memory_writeback u_mem_wb (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .wb         (wb)
    );

endmodule

//--- logic/dlx_pkg.sv
package dlx_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int imm16_w    = 16;
    localparam int imm26_w    = 26;
    // shift amount bits, log2 of the word
    localparam int shift_w    = 5;
    localparam int num_regs   = 1 << reg_addr_w;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // primary opcodes, dlx numbering
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beqz  = 6'h04,
        op_bnez  = 6'h05,
        op_addi  = 6'h08,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } op_t;

    // r-type function field, 0 is left free so the zero word is a nop
    typedef enum logic [5:0] {
        fn_sll = 6'h04,
        fn_srl = 6'h06,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_xor = 6'h26,
        fn_slt = 6'h2a
    } func_t;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_slt = 4'd7
    } alu_op_t;

    ////////////////////////////////////////
    // instruction word views
    ////////////////////////////////////////

    typedef struct packed {
        op_t                   op;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [shift_w-1:0]    shamt;
        func_t                 func;
    } r_fmt_t;

    // rd doubles as the store source for sw
    typedef struct packed {
        op_t                   op;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rd;
        logic [imm16_w-1:0]    imm16;
    } i_fmt_t;

    typedef struct packed {
        op_t                op;
        logic [imm26_w-1:0] imm26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_t;

    ////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////

    typedef struct packed {
        logic [xlen-1:0] pc4;
        instr_t          instr;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc4;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       store_val;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       jump_off;
        logic [reg_addr_w-1:0] dest;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_write;
        logic                  branch;
        logic                  branch_zero;
        logic                  jump;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       store_val;
        logic [reg_addr_w-1:0] dest;
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_write;
        logic                  leap;
        logic [xlen-1:0]       leap_addr;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       load_data;
        logic [reg_addr_w-1:0] dest;
        logic                  reg_write;
        logic                  mem_to_reg;
    } mem_wb_t;

    // data memory request, combinational read and strobed write
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            we;
    } dmem_req_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       value;
        logic                  en;
    } wb_t;

endpackage

//--- logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  dlx_pkg::id_ex_t   id_ex,
    output dlx_pkg::ex_mem_t  ex_mem
);

    logic [dlx_pkg::xlen-1:0]    opnd_a;
    logic [dlx_pkg::xlen-1:0]    opnd_b;
    logic [dlx_pkg::shift_w-1:0] shamt;
    logic                        less;
    logic [dlx_pkg::xlen-1:0]    alu_y;
    logic                        a_zero;
    logic                        taken;
    logic [dlx_pkg::xlen-1:0]    branch_tgt;
    logic [dlx_pkg::xlen-1:0]    jump_tgt;
    dlx_pkg::ex_mem_t            ex_mem_d;

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////

    assign opnd_a = id_ex.op_a;

    // second register rides in store_val
    assign opnd_b = id_ex.use_imm ? id_ex.imm : id_ex.store_val;

    // shifts by low bits of operand b
    assign shamt = opnd_b[dlx_pkg::shift_w-1:0];

    assign less = $signed(opnd_a) < $signed(opnd_b);

    always_comb begin
        case (id_ex.alu_op)
            dlx_pkg::alu_add: alu_y = opnd_a + opnd_b;
            dlx_pkg::alu_sub: alu_y = opnd_a - opnd_b;
            dlx_pkg::alu_and: alu_y = opnd_a & opnd_b;
            dlx_pkg::alu_or:  alu_y = opnd_a | opnd_b;
            dlx_pkg::alu_xor: alu_y = opnd_a ^ opnd_b;
            dlx_pkg::alu_sll: alu_y = opnd_a << shamt;
            dlx_pkg::alu_srl: alu_y = opnd_a >> shamt;
            // signed compare, 1 or 0
            dlx_pkg::alu_slt: alu_y = {{(dlx_pkg::xlen-1){1'b0}}, less};
            default:          alu_y = '0;
        endcase
    end

    ////////////////////////////////////////
    // branch resolution
    ////////////////////////////////////////

    assign a_zero = (opnd_a == '0);

    // beqz wants zero, bnez wants nonzero
    assign taken = id_ex.branch && (id_ex.branch_zero == a_zero);

    // both targets relative to pc + 4
    assign branch_tgt = id_ex.pc4 + id_ex.imm;
    assign jump_tgt   = id_ex.pc4 + id_ex.jump_off;

    always_comb begin
        ex_mem_d.alu_result = alu_y;
        ex_mem_d.store_val  = id_ex.store_val;
        ex_mem_d.dest       = id_ex.dest;
        ex_mem_d.reg_write  = id_ex.reg_write;
        ex_mem_d.mem_to_reg = id_ex.mem_to_reg;
        ex_mem_d.mem_write  = id_ex.mem_write;
        ex_mem_d.leap       = id_ex.jump | taken;
        ex_mem_d.leap_addr  = id_ex.jump ? jump_tgt : branch_tgt;
    end

    // ex/mem register
    // leap seen by fetch one cycle later, hence three slots
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  dlx_pkg::instr_t               imem_data,
    input  logic                          leap,
    input  logic [dlx_pkg::xlen-1:0]      leap_addr,
    output logic [dlx_pkg::xlen-1:0]      pc,
    output dlx_pkg::if_id_t               if_id
);

    logic [dlx_pkg::xlen-1:0] pc_plus4;
    logic [dlx_pkg::xlen-1:0] pc_next;

    assign pc_plus4 = pc + dlx_pkg::xlen'(4);

    // late leap from mem stage, no flush
    assign pc_next = leap ? leap_addr : pc_plus4;

    // program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // if/id register
    // imem is combinational so the word belongs to this pc
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id <= '0;
        end else begin
            if_id.pc4   <= pc_plus4;
            if_id.instr <= imem_data;
        end
    end

endmodule

//--- logic/memory_writeback.sv
`timescale 1ns/100ps

module memory_writeback (
    input  logic                          clk,
    input  logic                          rst,
    input  dlx_pkg::ex_mem_t              ex_mem,
    input  logic [dlx_pkg::xlen-1:0]      dmem_rdata,
    output dlx_pkg::dmem_req_t            dmem_req,
    output dlx_pkg::wb_t                  wb
);

    dlx_pkg::mem_wb_t mem_wb;

    ////////////////////////////////////////
    // memory access
    ////////////////////////////////////////

    // straight from ex/mem, write lands on the closing edge
    assign dmem_req.addr  = ex_mem.alu_result;
    assign dmem_req.wdata = ex_mem.store_val;
    assign dmem_req.we    = ex_mem.mem_write;

    // mem/wb register
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= dmem_rdata;
            mem_wb.dest       <= ex_mem.dest;
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
        end
    end

    ////////////////////////////////////////
    // writeback
    ////////////////////////////////////////

    // load data or alu result
    assign wb.dest  = mem_wb.dest;
    assign wb.value = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;
    assign wb.en    = mem_wb.reg_write;

endmodule

//--- logic/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [dlx_pkg::reg_addr_w-1:0]    rs1,
    input  logic [dlx_pkg::reg_addr_w-1:0]    rs2,
    input  dlx_pkg::wb_t                      wb,
    output logic [dlx_pkg::xlen-1:0]          rdata1,
    output logic [dlx_pkg::xlen-1:0]          rdata2
);

    logic [dlx_pkg::xlen-1:0] regs [dlx_pkg::num_regs];

    // write port, r0 stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dlx_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.dest != '0)) begin
            regs[wb.dest] <= wb.value;
        end
    end

    // read ports
    // write-through so decode sees a same-cycle writeback
    always_comb begin
        if (rs1 == '0) begin
            rdata1 = '0;
        end else if (wb.en && (wb.dest == rs1)) begin
            rdata1 = wb.value;
        end else begin
            rdata1 = regs[rs1];
        end

        if (rs2 == '0) begin
            rdata2 = '0;
        end else if (wb.en && (wb.dest == rs2)) begin
            rdata2 = wb.value;
        end else begin
            rdata2 = regs[rs2];
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the pipeline testbench, exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module dlx_tb -f sources.f -o dlx_sim
./obj_dir/dlx_sim

//--- sources.f
logic/dlx_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_writeback.sv
logic/dlx_pipeline.sv
tb/dlx_asserts.sv
tb/dlx_tb.sv

//--- tb/dlx_asserts.sv
`timescale 1ns/100ps

module dlx_asserts (
    input logic                     clk,
    input logic                     rst,
    input logic [dlx_pkg::xlen-1:0] imem_addr,
    input dlx_pkg::dmem_req_t       dmem_req
);

    ////////////////////////////////////////
    // reset behavior
    ////////////////////////////////////////

    // stage registers cleared, no store strobe
    a_quiet_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !dmem_req.we)
        else $error("store strobe high while reset is held");

    // empty pipe, a store needs three cycles to reach memory
    a_quiet_after_reset: assert property (@(posedge clk)
        (!rst && ($past(rst, 1) || $past(rst, 2) || $past(rst, 3))) |-> !dmem_req.we)
        else $error("store strobe high in the first three cycles after reset");

    ////////////////////////////////////////
    // bus legality
    ////////////////////////////////////////

    a_imem_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    // only word stores exist
    a_dmem_aligned: assert property (@(posedge clk)
        dmem_req.we |-> dmem_req.addr[1:0] == 2'b00)
        else $error("store address not word aligned");

endmodule

//--- tb/dlx_tb.sv
`timescale 1ns/100ps

module dlx_tb;

    localparam int timeout_cycles = 256 * 4 + 100;
    // no new branches past here, room left for the closing self jump
    localparam int end_limit      = 880;
    localparam int base_addr      = 512;

    logic                     clk;
    logic                     rst;
    dlx_pkg::instr_t          imem_data;
    logic [dlx_pkg::xlen-1:0] dmem_rdata;
    logic [dlx_pkg::xlen-1:0] imem_addr;
    dlx_pkg::dmem_req_t       dmem_req;

    // memories behind the two buses
    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    // reference model state and expected traffic
    logic [31:0] mreg [32];
    logic [31:0] mdm [256];
    logic [31:0] fetch_q [$];
    logic [31:0] st_addr_q [$];
    logic [31:0] st_data_q [$];

    int cycle      = 0;
    int st_idx     = 0;
    int run_cycles = 0;

    dlx_pipeline uut (
        .clk        (clk),
        .rst        (rst),
        .imem_data  (imem_data),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_req   (dmem_req)
    );

    bind dlx_pipeline dlx_asserts u_asserts (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .dmem_req  (dmem_req)
    );

    ////////////////////////////////////////
    // memory models
    ////////////////////////////////////////

    // combinational reads, same cycle as the address
    assign imem_data  = dlx_pkg::instr_t'(imem[imem_addr[9:2]]);
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    // store lands on the edge closing the cycle
    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    ////////////////////////////////////////
    // encoding helpers
    ////////////////////////////////////////

    function automatic logic [31:0] enc_r(dlx_pkg::func_t fn, logic [4:0] rs1,
                                          logic [4:0] rs2, logic [4:0] rd);
        return {dlx_pkg::op_rtype, rs1, rs2, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(dlx_pkg::op_t op, logic [4:0] rs1,
                                          logic [4:0] rd, logic [15:0] imm);
        return {op, rs1, rd, imm};
    endfunction

    function automatic logic [31:0] enc_j(logic [25:0] off);
        return {dlx_pkg::op_j, off};
    endfunction

    function automatic logic [31:0] sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // source not written by the last two instructions, r0 always safe
    function automatic logic [4:0] pick_src(logic [4:0] rec0, logic [4:0] rec1);
        logic [4:0] r;
        do begin
            r = 5'($urandom % 32);
        end while (r != 5'd0 && (r == rec0 || r == rec1));
        return r;
    endfunction

    // base register is kept, pending load target too
    function automatic logic [4:0] pick_dst(logic [4:0] ld_reg, int ld_wait);
        logic [4:0] r;
        do begin
            r = 5'($urandom % 32);
        end while (r == 5'd1 || (ld_wait > 0 && r == ld_reg));
        return r;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    ////////////////////////////////////////
    // program generation and model
    ////////////////////////////////////////

    // each word is generated when the model first reaches it
    task automatic build_program();
        logic [31:0]    pc;
        logic [31:0]    next_pc;
        logic [31:0]    tgt;
        logic [31:0]    leap_tgt;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    res;
        logic [31:0]    addr;
        logic [31:0]    w;
        logic [15:0]    imm;
        logic [4:0]     rs_a;
        logic [4:0]     rs_b;
        logic [4:0]     rd;
        logic [4:0]     wr_reg;
        logic [4:0]     rec0;
        logic [4:0]     rec1;
        logic [4:0]     ld_reg;
        dlx_pkg::func_t fn;
        int             slot_left;
        int             ld_wait;
        int             pick;
        int             off;
        logic           leap_pending;
        logic           in_slot;
        logic           is_cti;
        logic           taken;
        logic           r1_recent;
        logic           done;

        for (int i = 0; i < 256; i++) begin
            w       = $urandom;
            imem[i] = '0;
            dmem[i] <= w;
            mdm[i]  = w;
        end
        for (int i = 0; i < 32; i++) begin
            mreg[i] = '0;
        end

        // base register for all data addresses
        imem[0] = enc_i(dlx_pkg::op_addi, 5'd0, 5'd1, 16'(base_addr));
        mreg[1] = 32'(base_addr);
        fetch_q.push_back(32'd0);
        pc           = 32'd4;
        rec0         = 5'd1;
        rec1         = 5'd0;
        ld_reg       = 5'd0;
        ld_wait      = 0;
        slot_left    = 0;
        leap_pending = 1'b0;
        leap_tgt     = '0;
        tgt          = '0;
        done         = 1'b0;

        while (!done) begin
            in_slot   = (slot_left > 0);
            r1_recent = (rec0 == 5'd1 || rec1 == 5'd1);
            is_cti    = 1'b0;
            taken     = 1'b0;
            wr_reg    = 5'd0;
            pick      = int'($urandom % 100);
            rs_a      = pick_src(rec0, rec1);
            rs_b      = pick_src(rec0, rec1);
            rd        = pick_dst(ld_reg, ld_wait);
            imm       = 16'($urandom);
            a         = mreg[rs_a];
            b         = mreg[rs_b];
            fetch_q.push_back(pc);

            if (pc >= 32'(end_limit) && !in_slot) begin
                // self jump, target = pc + 4 - 4
                imem[pc[9:2]] = enc_j(26'(-4));
                done          = 1'b1;
            end else if (ld_wait == 1 || (pick < 22 && !r1_recent)) begin
                // store, the paired one writes back the loaded register
                if (ld_wait == 1) begin
                    rs_b = ld_reg;
                end
                off  = int'($urandom % 256) - 128;
                imm  = 16'(off * 4);
                addr = mreg[1] + sext16(imm);
                imem[pc[9:2]]  = enc_i(dlx_pkg::op_sw, 5'd1, rs_b, imm);
                mdm[addr[9:2]] = mreg[rs_b];
                st_addr_q.push_back(addr);
                st_data_q.push_back(mreg[rs_b]);
            end else if (pick < 34 && !r1_recent) begin
                off  = int'($urandom % 256) - 128;
                imm  = 16'(off * 4);
                addr = mreg[1] + sext16(imm);
                imem[pc[9:2]] = enc_i(dlx_pkg::op_lw, 5'd1, rd, imm);
                res    = mdm[addr[9:2]];
                wr_reg = rd;
                // store of this register three instructions on
                if (ld_wait == 0 && rd != 5'd0) begin
                    ld_reg  = rd;
                    ld_wait = 4;
                end
            end else if (pick < 46 && !in_slot && pc < 32'(end_limit)) begin
                // forward only, always past the three slots
                off    = 4 * (3 + int'($urandom % 8));
                tgt    = pc + 32'd4 + 32'(off);
                is_cti = 1'b1;
                case ($urandom % 3)
                    0: begin
                        imem[pc[9:2]] = enc_i(dlx_pkg::op_beqz, rs_a, 5'd0, 16'(off));
                        taken         = (a == '0);
                    end
                    1: begin
                        imem[pc[9:2]] = enc_i(dlx_pkg::op_bnez, rs_a, 5'd0, 16'(off));
                        taken         = (a != '0);
                    end
                    default: begin
                        imem[pc[9:2]] = enc_j(26'(off));
                        taken         = 1'b1;
                    end
                endcase
            end else if (pick < 70) begin
                wr_reg = rd;
                // addi sign extends, the logical ones zero extend
                case ($urandom % 4)
                    0: begin
                        imem[pc[9:2]] = enc_i(dlx_pkg::op_addi, rs_a, rd, imm);
                        res           = a + sext16(imm);
                    end
                    1: begin
                        imem[pc[9:2]] = enc_i(dlx_pkg::op_andi, rs_a, rd, imm);
                        res           = a & {16'd0, imm};
                    end
                    2: begin
                        imem[pc[9:2]] = enc_i(dlx_pkg::op_ori, rs_a, rd, imm);
                        res           = a | {16'd0, imm};
                    end
                    default: begin
                        imem[pc[9:2]] = enc_i(dlx_pkg::op_xori, rs_a, rd, imm);
                        res           = a ^ {16'd0, imm};
                    end
                endcase
            end else begin
                wr_reg = rd;
                case ($urandom % 8)
                    0: begin
                        fn  = dlx_pkg::fn_add;
                        res = a + b;
                    end
                    1: begin
                        fn  = dlx_pkg::fn_sub;
                        res = a - b;
                    end
                    2: begin
                        fn  = dlx_pkg::fn_and;
                        res = a & b;
                    end
                    3: begin
                        fn  = dlx_pkg::fn_or;
                        res = a | b;
                    end
                    4: begin
                        fn  = dlx_pkg::fn_xor;
                        res = a ^ b;
                    end
                    5: begin
                        fn  = dlx_pkg::fn_sll;
                        res = a << b[4:0];
                    end
                    6: begin
                        fn  = dlx_pkg::fn_srl;
                        res = a >> b[4:0];
                    end
                    default: begin
                        fn  = dlx_pkg::fn_slt;
                        res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    end
                endcase
                imem[pc[9:2]] = enc_r(fn, rs_a, rs_b, rd);
            end

            // r0 never changes
            if (wr_reg != 5'd0) begin
                mreg[wr_reg] = res;
            end
            rec1 = rec0;
            rec0 = wr_reg;
            if (ld_wait > 0) begin
                ld_wait--;
            end

            // three delay slots, then the leap
            next_pc = pc + 32'd4;
            if (slot_left > 0) begin
                slot_left--;
                if (slot_left == 0 && leap_pending) begin
                    next_pc      = leap_tgt;
                    leap_pending = 1'b0;
                end
            end
            if (is_cti) begin
                slot_left    = 3;
                leap_pending = taken;
                leap_tgt     = tgt;
            end
            if (!done) begin
                pc = next_pc;
            end
        end

        // two laps of the closing loop, nop slots
        for (int k = 1; k <= 8; k++) begin
            fetch_q.push_back(pc + 32'(4 * (k % 4)));
        end
    endtask

    ////////////////////////////////////////
    // clock, reset, stimulus
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst <= 1'b1;
        void'($urandom(32'h837b));
        build_program();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

    ////////////////////////////////////////
    // response checks
    ////////////////////////////////////////

    // sampled mid cycle, outputs settled
    always @(negedge clk) begin
        if (!rst) begin
            if (cycle < 3) begin
                check_value("no store after reset", 32'd0, 32'(dmem_req.we));
            end
            if (dmem_req.we && st_idx >= st_addr_q.size()) begin
                $display("store at cycle %0d has no match in the model", cycle);
                $display("TB FAILED");
                $fatal(1, "unexpected store");
            end else if (dmem_req.we) begin
                check_value($sformatf("store %0d address", st_idx), st_addr_q[st_idx],
                            dmem_req.addr);
                check_value($sformatf("store %0d data", st_idx), st_data_q[st_idx],
                            dmem_req.wdata);
                st_idx++;
            end
            check_value($sformatf("fetch %0d", cycle), fetch_q[cycle], imem_addr);
            cycle++;
            if (cycle == fetch_q.size()) begin
                if (st_idx == st_addr_q.size()) begin
                    $display("TB PASSED");
                    $finish;
                end else begin
                    $display("fetch sequence ended with %0d stores never seen",
                             st_addr_q.size() - st_idx);
                    $display("TB FAILED");
                    $fatal(1, "missing stores");
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles >= timeout_cycles) begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule
